//--- accel_config.svh
`ifndef ACCEL_CONFIG_SVH
`define ACCEL_CONFIG_SVH

// width of one memory page in bits
`define ACCEL_PAGE_BITS 128

// program is 4 instructions per page
`define ACCEL_PROG_PAGES 4

`define ACCEL_IMG_PAGES 4

`define ACCEL_WEIGHT_PAGES 3

// larger of program and image page counts
`define ACCEL_BUF_DEPTH 4

`endif

//--- accel_pkg.sv
`include "accel_config.svh"

package accel_pkg;

    typedef logic [`ACCEL_PAGE_BITS-1:0] page_t;
    typedef logic [31:0] addr_t;
    typedef logic [27:0] operand_t;
    // opcode in [31:28], operand below
    typedef logic [31:0] instr_t;
    // low bits of the register-setting opcodes
    typedef logic [1:0] reg_sel_t;

    typedef enum logic [3:0] {
        OP_SET_IMG_ADDR  = 4'd0,
        OP_SET_IMG_CNT   = 4'd1,
        OP_SET_RSLT_ADDR = 4'd2,
        OP_LOAD_RDN      = 4'd3,
        OP_LOAD_DNN      = 4'd4,
        OP_PROC          = 4'd5,
        OP_HALT          = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        WAIT_BUFFER,
        FETCH_PROGRAM_PAGE,
        WAIT_PROGRAM_PAGE,
        EXECUTING,
        WAIT_RDN_LOAD,
        WAIT_DNN_LOAD,
        WAIT_IMAGE,
        DONE_IMG
    } ctrl_state_e;

endpackage

//--- page_buffer.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module page_buffer
    import accel_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  page_t d,
    output logic [`ACCEL_BUF_DEPTH*`ACCEL_PAGE_BITS-1:0] q
);

    localparam int W = `ACCEL_PAGE_BITS;
    localparam int D = `ACCEL_BUF_DEPTH;

    // new page enters at the top, entry 0 ends up holding the oldest
    always_ff @(posedge clk) begin
        if (en) begin
            q <= {d, q[D*W-1:W]};
        end
    end

    a_known_page: assert property (
        @(posedge clk) disable iff (!rst_n)
        en |-> !$isunknown(d)
    );

endmodule

//--- ctrl_unit.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module ctrl_unit
    import accel_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     buffer_addr_valid,
    input  logic     data_valid,
    input  logic     write_done,
    input  page_t    read_data,
    output addr_t    address,
    output page_t    write_data,
    output logic     read_request_valid,
    output logic     write_request_valid,
    output logic     inc_pc,
    output logic     instr_vld,
    input  logic     begin_rdn_load,
    input  logic     begin_dnn_load,
    input  logic     begin_proc,
    input  reg_sel_t reg_sel,
    input  logic     reg_wr_en,
    input  operand_t reg_databus,
    input  logic     rdn_req,
    input  logic     dnn_req,
    input  logic     rdn_done,
    input  logic     dnn_done,
    input  logic     res_vld,
    input  page_t    result,
    output logic     rdn_start,
    output logic     dnn_start,
    output logic     img_done,
    output logic     buf_en
);

    localparam int PW = $clog2(`ACCEL_BUF_DEPTH);
    localparam logic [PW-1:0] PROG_LAST = PW'(`ACCEL_PROG_PAGES - 1);
    localparam logic [PW-1:0] IMG_LAST = PW'(`ACCEL_IMG_PAGES - 1);

    ctrl_state_e state;
    logic [PW-1:0] pg_cnt;
    addr_t img_addr;
    addr_t rslt_addr;
    addr_t ld_addr;
    operand_t img_cnt;
    logic pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= WAIT_BUFFER;
            pg_cnt <= '0;
            ld_addr <= '0;
            read_request_valid <= 1'b0;
            write_request_valid <= 1'b0;
            inc_pc <= 1'b0;
            instr_vld <= 1'b0;
            rdn_start <= 1'b0;
            dnn_start <= 1'b0;
            img_done <= 1'b0;
        end else begin
            read_request_valid <= 1'b0;
            write_request_valid <= 1'b0;
            inc_pc <= 1'b0;
            instr_vld <= 1'b0;
            rdn_start <= 1'b0;
            dnn_start <= 1'b0;
            img_done <= 1'b0;
            case (state)
                WAIT_BUFFER: begin
                    if (buffer_addr_valid) begin
                        state <= FETCH_PROGRAM_PAGE;
                        read_request_valid <= 1'b1;
                    end
                end
                FETCH_PROGRAM_PAGE: begin
                    state <= WAIT_PROGRAM_PAGE;
                end
                WAIT_PROGRAM_PAGE: begin
                    if (data_valid) begin
                        pg_cnt <= pg_cnt + 1'b1;
                        if (pg_cnt == PROG_LAST) begin
                            state <= EXECUTING;
                            instr_vld <= 1'b1;
                        end else begin
                            state <= FETCH_PROGRAM_PAGE;
                            read_request_valid <= 1'b1;
                        end
                    end
                end
                EXECUTING: begin
                    ld_addr <= addr_t'(reg_databus);
                    if (begin_rdn_load) begin
                        state <= WAIT_RDN_LOAD;
                        rdn_start <= 1'b1;
                    end else if (begin_dnn_load) begin
                        state <= WAIT_DNN_LOAD;
                        dnn_start <= 1'b1;
                    end else if (begin_proc) begin
                        state <= WAIT_IMAGE;
                        pg_cnt <= '0;
                        read_request_valid <= 1'b1;
                    end
                end
                WAIT_RDN_LOAD, WAIT_DNN_LOAD: begin
                    // only the active store raises req or done
                    if (rdn_req || dnn_req) begin
                        read_request_valid <= 1'b1;
                    end
                    if (data_valid) begin
                        ld_addr <= ld_addr + 1'b1;
                    end
                    if (rdn_done || dnn_done) begin
                        state <= EXECUTING;
                        inc_pc <= 1'b1;
                    end
                end
                WAIT_IMAGE: begin
                    if (data_valid) begin
                        pg_cnt <= pg_cnt + 1'b1;
                        if (pg_cnt == IMG_LAST) begin
                            state <= DONE_IMG;
                            img_done <= 1'b1;
                        end else begin
                            read_request_valid <= 1'b1;
                        end
                    end
                end
                DONE_IMG: begin
                    if (res_vld) begin
                        write_request_valid <= 1'b1;
                    end
                    if (write_done) begin
                        if (img_cnt > 1) begin
                            state <= WAIT_IMAGE;
                            pg_cnt <= '0;
                            read_request_valid <= 1'b1;
                        end else begin
                            state <= EXECUTING;
                            inc_pc <= 1'b1;
                        end
                    end
                end
                default: state <= WAIT_BUFFER;
            endcase
        end
    end

    // register file, sel 0/1/2 = img_addr/img_cnt/rslt_addr
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_addr <= '0;
            img_cnt <= '0;
            rslt_addr <= '0;
        end else if (reg_wr_en) begin
            case (reg_sel)
                2'd0: img_addr <= addr_t'(reg_databus);
                2'd1: img_cnt <= reg_databus;
                2'd2: rslt_addr <= addr_t'(reg_databus);
                default: ;
            endcase
        end else begin
            if (state == WAIT_IMAGE && data_valid) begin
                img_addr <= img_addr + 1'b1;
            end
            if (state == DONE_IMG && write_done) begin
                img_cnt <= img_cnt - 1'b1;
                rslt_addr <= rslt_addr + 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            FETCH_PROGRAM_PAGE, WAIT_PROGRAM_PAGE: address = addr_t'(pg_cnt);
            WAIT_RDN_LOAD, WAIT_DNN_LOAD: address = ld_addr;
            WAIT_IMAGE: address = img_addr;
            DONE_IMG: address = rslt_addr;
            default: address = '0;
        endcase
    end

    assign buf_en = data_valid && (state == WAIT_PROGRAM_PAGE || state == WAIT_IMAGE);
    assign write_data = result;

    // one transaction in flight at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (read_request_valid || write_request_valid) begin
            pending <= 1'b1;
        end else if (data_valid || write_done) begin
            pending <= 1'b0;
        end
    end

    a_req_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(read_request_valid && write_request_valid)
    );

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (read_request_valid || write_request_valid) |-> !pending
    );

    a_weight_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (data_valid && (state == WAIT_RDN_LOAD || state == WAIT_DNN_LOAD))
            |-> !$isunknown(read_data)
    );

endmodule

//--- instr_seq.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module instr_seq
    import accel_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_vld,
    input  logic     inc_pc,
    input  logic [`ACCEL_BUF_DEPTH*`ACCEL_PAGE_BITS-1:0] prog,
    output logic     begin_rdn_load,
    output logic     begin_dnn_load,
    output logic     begin_proc,
    output reg_sel_t reg_sel,
    output logic     reg_wr_en,
    output operand_t reg_databus,
    output logic     halted
);

    localparam int N_INSTR = `ACCEL_PROG_PAGES * 4;
    localparam int PC_W = $clog2(N_INSTR);
    // program sits in the newest buffer entries
    localparam int BASE = (`ACCEL_BUF_DEPTH - `ACCEL_PROG_PAGES) * `ACCEL_PAGE_BITS;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_WAIT, SEQ_HALT} seq_state_e;

    seq_state_e state;
    logic [PC_W-1:0] pc;
    logic [`ACCEL_BUF_DEPTH*`ACCEL_PAGE_BITS-1:0] prog_q;
    instr_t instr;
    opcode_e opcode;

    // own copy since the buffer is reused for image pages
    always_ff @(posedge clk) begin
        if (instr_vld) begin
            prog_q <= prog;
        end
    end

    assign instr = prog_q[BASE + 32*pc +: 32];
    assign opcode = opcode_e'(instr[31:28]);
    assign reg_sel = instr[29:28];
    assign reg_databus = instr[27:0];
    assign halted = (state == SEQ_HALT);

    always_comb begin
        reg_wr_en = 1'b0;
        begin_rdn_load = 1'b0;
        begin_dnn_load = 1'b0;
        begin_proc = 1'b0;
        if (state == SEQ_RUN) begin
            case (opcode)
                OP_SET_IMG_ADDR, OP_SET_IMG_CNT, OP_SET_RSLT_ADDR: reg_wr_en = 1'b1;
                OP_LOAD_RDN: begin_rdn_load = 1'b1;
                OP_LOAD_DNN: begin_dnn_load = 1'b1;
                OP_PROC: begin_proc = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
            pc <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (instr_vld) begin
                        state <= SEQ_RUN;
                        pc <= '0;
                    end
                end
                SEQ_RUN: begin
                    if (reg_wr_en) begin
                        pc <= pc + 1'b1;
                    end else if (begin_rdn_load || begin_dnn_load || begin_proc) begin
                        state <= SEQ_WAIT;
                    end else begin
                        // OP_HALT or anything unknown
                        state <= SEQ_HALT;
                    end
                end
                SEQ_WAIT: begin
                    if (inc_pc) begin
                        state <= SEQ_RUN;
                        pc <= pc + 1'b1;
                    end
                end
                default: state <= SEQ_HALT;
            endcase
        end
    end

    a_inc_pc_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        inc_pc |-> state == SEQ_WAIT
    );

endmodule

//--- weight_store.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module weight_store
    import accel_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start,
    input  logic  page_vld,
    input  page_t page,
    output logic  weight_req,
    output logic  weight_done,
    output page_t weights
);

    localparam int CW = $clog2(`ACCEL_WEIGHT_PAGES + 1);
    localparam logic [CW-1:0] LAST = CW'(`ACCEL_WEIGHT_PAGES - 1);

    logic active;
    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt <= '0;
            weights <= '0;
            weight_req <= 1'b0;
            weight_done <= 1'b0;
        end else begin
            weight_req <= 1'b0;
            weight_done <= 1'b0;
            if (start) begin
                active <= 1'b1;
                cnt <= '0;
                weights <= '0;
                weight_req <= 1'b1;
            end else if (active && page_vld) begin
                // fold page into accumulator
                weights <= weights ^ page;
                cnt <= cnt + 1'b1;
                if (cnt == LAST) begin
                    active <= 1'b0;
                    weight_done <= 1'b1;
                end else begin
                    weight_req <= 1'b1;
                end
            end
        end
    end

endmodule

//--- result_unit.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module result_unit
    import accel_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  img_done,
    input  logic [`ACCEL_BUF_DEPTH*`ACCEL_PAGE_BITS-1:0] pages,
    output logic  res_vld,
    output page_t result
);

    localparam int W = `ACCEL_PAGE_BITS;
    // image occupies the newest entries
    localparam int FIRST = `ACCEL_BUF_DEPTH - `ACCEL_IMG_PAGES;

    page_t fold;

    always_comb begin
        fold = '0;
        for (int i = 0; i < `ACCEL_IMG_PAGES; i++) begin
            fold = fold ^ pages[(FIRST + i)*W +: W];
        end
    end

    always_ff @(posedge clk) begin
        if (img_done) begin
            result <= fold;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_vld <= 1'b0;
        end else begin
            res_vld <= img_done;
        end
    end

endmodule

//--- accel_top.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module accel_top
    import accel_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  buffer_addr_valid,
    input  logic  data_valid,
    input  logic  write_done,
    input  page_t read_data,
    output addr_t address,
    output page_t write_data,
    output logic  read_request_valid,
    output logic  write_request_valid,
    output logic  halted,
    output page_t rdn_weights,
    output page_t dnn_weights
);

    logic [`ACCEL_BUF_DEPTH*`ACCEL_PAGE_BITS-1:0] buf_q;
    logic     buf_en;
    logic     instr_vld;
    logic     inc_pc;
    logic     begin_rdn_load;
    logic     begin_dnn_load;
    logic     begin_proc;
    reg_sel_t reg_sel;
    logic     reg_wr_en;
    operand_t reg_databus;
    logic     rdn_start;
    logic     dnn_start;
    logic     rdn_req;
    logic     dnn_req;
    logic     rdn_done;
    logic     dnn_done;
    logic     img_done;
    logic     res_vld;
    page_t    result;

    ctrl_unit u_ctrl (.*);

    page_buffer u_buf (
        .clk(clk), .rst_n(rst_n), .en(buf_en), .d(read_data), .q(buf_q)
    );

    instr_seq u_seq (
        .clk(clk), .rst_n(rst_n), .instr_vld(instr_vld), .inc_pc(inc_pc), .prog(buf_q),
        .begin_rdn_load(begin_rdn_load), .begin_dnn_load(begin_dnn_load),
        .begin_proc(begin_proc), .reg_sel(reg_sel), .reg_wr_en(reg_wr_en),
        .reg_databus(reg_databus), .halted(halted)
    );

    weight_store u_rdn (
        .clk(clk), .rst_n(rst_n), .start(rdn_start), .page_vld(data_valid),
        .page(read_data), .weight_req(rdn_req), .weight_done(rdn_done),
        .weights(rdn_weights)
    );

    weight_store u_dnn (
        .clk(clk), .rst_n(rst_n), .start(dnn_start), .page_vld(data_valid),
        .page(read_data), .weight_req(dnn_req), .weight_done(dnn_done),
        .weights(dnn_weights)
    );

    result_unit u_res (
        .clk(clk), .rst_n(rst_n), .img_done(img_done), .pages(buf_q),
        .res_vld(res_vld), .result(result)
    );

endmodule

//--- tb_accel.sv
`timescale 1ns/1ps
`include "accel_config.svh"

module tb_accel
    import accel_pkg::*;
();

    // two runs of 25 transactions at up to about 8 cycles each plus reset and idle gaps
    localparam int MAX_CYCLES = 2000;
    localparam int N_READS = `ACCEL_PROG_PAGES + 2 * `ACCEL_WEIGHT_PAGES + 3 * `ACCEL_IMG_PAGES;
    localparam int N_IMGS = 3;
    localparam int MEM_PAGES = 128;
    localparam int N_TESTS = 6;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    logic  buffer_addr_valid = 1'b0;
    logic  data_valid = 1'b0;
    logic  write_done = 1'b0;
    page_t read_data = '0;
    addr_t address;
    page_t write_data;
    logic  read_request_valid;
    logic  write_request_valid;
    logic  halted;
    page_t rdn_weights;
    page_t dnn_weights;

    page_t mem [MEM_PAGES];
    addr_t exp_rd [N_READS];
    logic [31:0] lfsr = 32'hc5aec051;
    int    run = 1;
    logic  fixed_lat = 1'b0;
    logic  started = 1'b0;
    int    cycles = 0;
    int    err [N_TESTS] = '{default: 0};
    string names [N_TESTS] = '{"idle", "prog_fetch", "weights", "images", "halt_quiet",
                               "fixed_latency"};

    // memory model state
    logic  busy = 1'b0;
    logic  req_wr = 1'b0;
    addr_t req_addr = '0;
    int    wait_left = 0;
    int    rd_idx = 0;
    int    wr_cnt [2] = '{default: 0};
    int    done_cnt [2] = '{default: 0};
    addr_t wr_addr [2][8];
    page_t wr_data [2][8];

    accel_top dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not reach halted within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int owner(input int id);
        return (run == 2) ? N_TESTS - 1 : id;
    endfunction

    function automatic instr_t encode(input opcode_e op, input int arg);
        return {op, operand_t'(arg)};
    endfunction

    function automatic page_t fold_pages(input int base, input int n);
        page_t acc;
        acc = '0;
        for (int i = 0; i < n; i++) begin
            acc = acc ^ mem[base + i];
        end
        return acc;
    endfunction

    task automatic fill_memory();
        instr_t prog [16];
        for (int a = 0; a < MEM_PAGES; a++) begin
            for (int w = 0; w < `ACCEL_PAGE_BITS / 32; w++) begin
                mem[a][32*w +: 32] = rand_bits(32) ^ a;
            end
        end
        for (int i = 0; i < 16; i++) begin
            prog[i] = encode(OP_HALT, 0);
        end
        prog[0] = encode(OP_SET_IMG_ADDR, 40);
        prog[1] = encode(OP_SET_IMG_CNT, N_IMGS);
        prog[2] = encode(OP_SET_RSLT_ADDR, 80);
        prog[3] = encode(OP_LOAD_RDN, 16);
        prog[4] = encode(OP_LOAD_DNN, 24);
        prog[5] = encode(OP_PROC, 0);
        // lowest bits of page p hold instruction 4p
        for (int i = 0; i < 16; i++) begin
            mem[i / 4][32*(i % 4) +: 32] = prog[i];
        end
        for (int i = 0; i < N_READS; i++) begin
            if (i < `ACCEL_PROG_PAGES) begin
                exp_rd[i] = i;
            end else if (i < `ACCEL_PROG_PAGES + `ACCEL_WEIGHT_PAGES) begin
                exp_rd[i] = 16 + i - `ACCEL_PROG_PAGES;
            end else if (i < `ACCEL_PROG_PAGES + 2 * `ACCEL_WEIGHT_PAGES) begin
                exp_rd[i] = 24 + i - `ACCEL_PROG_PAGES - `ACCEL_WEIGHT_PAGES;
            end else begin
                exp_rd[i] = 40 + i - `ACCEL_PROG_PAGES - 2 * `ACCEL_WEIGHT_PAGES;
            end
        end
    endtask

    task automatic expect_page(input int id, input page_t exp, input page_t act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", names[id], exp, act);
            err[id]++;
        end
    endtask

    task automatic expect_int(input int id, input int exp, input int act);
        assert (act == exp) else begin
            $display("FAILED %s: expected %0d, actual %0d", names[id], exp, act);
            err[id]++;
        end
    endtask

    task automatic check_read(input addr_t a);
        int id;
        id = owner(rd_idx < 4 ? 1 : (rd_idx < 10 ? 2 : 3));
        if (rd_idx >= N_READS) begin
            $display("ERROR %s: extra read request at address %0d", names[id], a);
            err[id]++;
        end else begin
            expect_int(id, exp_rd[rd_idx], a);
        end
        rd_idx++;
    endtask

    // one outstanding request answered 1 to 4 cycles later
    always @(negedge clk) begin
        data_valid = 1'b0;
        write_done = 1'b0;
        if (!rst_n) begin
            busy = 1'b0;
            rd_idx = 0;
        end else if (busy) begin
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                busy = 1'b0;
                if (req_wr) begin
                    write_done = 1'b1;
                    done_cnt[run-1]++;
                end else begin
                    data_valid = 1'b1;
                    read_data = mem[req_addr % MEM_PAGES];
                end
            end
        end else if (read_request_valid || write_request_valid) begin
            busy = 1'b1;
            req_wr = write_request_valid;
            req_addr = address;
            wait_left = fixed_lat ? 1 : 1 + int'(rand_bits(2));
            if (req_wr) begin
                if (wr_cnt[run-1] < 8) begin
                    wr_addr[run-1][wr_cnt[run-1]] = address;
                    wr_data[run-1][wr_cnt[run-1]] = write_data;
                end
                wr_cnt[run-1]++;
            end else begin
                check_read(address);
            end
        end
    end

    a_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        !started |-> !(read_request_valid || write_request_valid || halted)
    ) else begin
        $display("ERROR %s: activity before buffer_addr_valid", names[owner(0)]);
        err[owner(0)]++;
    end

    a_halt_quiet: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |-> !(read_request_valid || write_request_valid)
    ) else begin
        $display("ERROR %s: request issued after halted", names[owner(4)]);
        err[owner(4)]++;
    end

    task automatic start_run(input int r, input logic fixed);
        run = r;
        fixed_lat = fixed;
        started = 1'b0;
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        // quiet window before the start strobe
        repeat (10) @(negedge clk);
        buffer_addr_valid = 1'b1;
        started = 1'b1;
        @(negedge clk);
        buffer_addr_valid = 1'b0;
        while (!halted) @(negedge clk);
    endtask

    task automatic report(input int id);
        if (err[id] == 0) begin
            $display("test %s: ok", names[id]);
        end else begin
            $display("test %s: %0d errors", names[id], err[id]);
        end
    endtask

    initial begin
        page_t rdn1;
        page_t dnn1;
        int passed;
        int total;
        fill_memory();
        start_run(1, 1'b0);
        report(0);
        report(1);
        expect_page(2, fold_pages(16, `ACCEL_WEIGHT_PAGES), rdn_weights);
        expect_page(2, fold_pages(24, `ACCEL_WEIGHT_PAGES), dnn_weights);
        report(2);
        expect_int(3, N_READS, rd_idx);
        expect_int(3, N_IMGS, wr_cnt[0]);
        for (int k = 0; k < N_IMGS; k++) begin
            expect_int(3, 80 + k, wr_addr[0][k]);
            expect_page(3, fold_pages(40 + 4*k, `ACCEL_IMG_PAGES), wr_data[0][k]);
        end
        report(3);
        expect_int(4, N_IMGS, done_cnt[0]);
        rdn1 = rdn_weights;
        dnn1 = dnn_weights;
        repeat (20) @(negedge clk);
        expect_int(4, N_READS, rd_idx);
        expect_int(4, N_IMGS, wr_cnt[0]);
        report(4);

        // same program and memory with every response after exactly one cycle
        start_run(2, 1'b1);
        repeat (20) @(negedge clk);
        expect_int(5, N_READS, rd_idx);
        expect_int(5, wr_cnt[0], wr_cnt[1]);
        expect_int(5, done_cnt[0], done_cnt[1]);
        for (int k = 0; k < N_IMGS; k++) begin
            expect_int(5, wr_addr[0][k], wr_addr[1][k]);
            expect_page(5, wr_data[0][k], wr_data[1][k]);
        end
        expect_page(5, rdn1, rdn_weights);
        expect_page(5, dnn1, dnn_weights);
        report(5);

        passed = 0;
        total = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            if (err[i] == 0) begin
                passed++;
            end
            total += err[i];
        end
        $display("%0d of %0d tests passed, %0d errors", passed, N_TESTS, total);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
accel_pkg.sv
page_buffer.sv
ctrl_unit.sv
instr_seq.sv
weight_store.sv
result_unit.sv
accel_top.sv
tb_accel.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_accel
FILELIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
